//--- project.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_ctrl.sv
ex_wb_reg.sv
ex_stage.sv
tb_ex_stage.sv

//--- tb_ex_stage.sv
/*
  Table-driven testbench for the execute stage with ALU and multiply
  reference model, EX/WB register model, check task and cycle watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int unsigned SHAMT_W = $clog2(DATA_W);

  // One stimulus row
  typedef struct packed {
    alu_req_t          alu;
    mult_req_t         mult;
    logic              csr_acc;
    logic [DATA_W-1:0] csr_data;
    logic              branch;
    logic              lsu_rdy;
    logic              wb_rdy;
    rf_wr_t            rf_alu;
    rf_wr_t            rf_lsu;
  } row_t;

  // Expected values of one row
  typedef struct packed {
    logic [DATA_W-1:0] wdata;
    logic              cmp;
    logic              valid;
    logic              ready;
  } exp_t;

  logic              clk;
  logic              rst_n;
  alu_req_t          alu_req_i;
  mult_req_t         mult_req_i;
  logic              csr_access_i;
  logic [DATA_W-1:0] csr_rdata_i;
  logic              branch_in_ex_i;
  rf_wr_t            rf_alu_i;
  rf_wr_t            rf_lsu_i;
  logic              lsu_ready_ex_i;
  logic              wb_ready_i;
  fw_t               fw_o;
  rf_wr_t            rf_wb_o;
  logic [DATA_W-1:0] jump_target_o;
  logic              branch_decision_o;
  logic              mult_multicycle_o;
  logic              ex_ready_o;
  logic              ex_valid_o;

  row_t    rows[$];
  exp_t    exps[$];
  string   names[$];
  rf_wr_t  wb_m;
  row_t    r;
  alu_op_e op;
  int      seed;
  int      n;
  int      cyc_cnt;
  int      limit_cyc;

  ex_stage #(
    .DATA_W (DATA_W)
  ) uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req_i),
    .mult_req_i        (mult_req_i),
    .csr_access_i      (csr_access_i),
    .csr_rdata_i       (csr_rdata_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .rf_alu_i          (rf_alu_i),
    .rf_lsu_i          (rf_lsu_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .wb_ready_i        (wb_ready_i),
    .fw_o              (fw_o),
    .rf_wb_o           (rf_wb_o),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .mult_multicycle_o (mult_multicycle_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog, limit known once the table is built
  initial
  begin
    cyc_cnt = 0;
  end

  always @(posedge clk)
  begin
    cyc_cnt = cyc_cnt + 1;
    if (limit_cyc != 0 && cyc_cnt >= limit_cyc)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit_cyc);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation hang");
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Returns {compare, result word}
  function automatic logic [DATA_W:0] alu_model(alu_op_e o, logic [DATA_W-1:0] a,
                                                logic [DATA_W-1:0] b);
    logic              lt_s;
    logic              lt_u;
    logic              cmp;
    logic [DATA_W-1:0] res;
    lt_s = ($signed(a) < $signed(b));
    lt_u = (a < b);
    cmp  = 1'b0;
    res  = '0;
    case (o)
      ADD:  res = a + b;
      SUB:  res = a - b;
      AND:  res = a & b;
      OR:   res = a | b;
      XOR:  res = a ^ b;
      SLL:  res = a << b[SHAMT_W-1:0];
      SRL:  res = a >> b[SHAMT_W-1:0];
      SRA:  res = $signed(a) >>> b[SHAMT_W-1:0];
      // Set-less-than also drives the compare output
      SLT:
      begin
        res = {{(DATA_W-1){1'b0}}, lt_s};
        cmp = lt_s;
      end
      SLTU:
      begin
        res = {{(DATA_W-1){1'b0}}, lt_u};
        cmp = lt_u;
      end
      EQ:   cmp = (a == b);
      NE:   cmp = (a != b);
      LT:   cmp = lt_s;
      GE:   cmp = !lt_s;
      LTU:  cmp = lt_u;
      GEU:  cmp = !lt_u;
      default: cmp = 1'b0;
    endcase
    return {cmp, res};
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    return $random(seed);
  endfunction

  // Plain ALU row, all stages ready
  function automatic row_t base_row(alu_op_e o, logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    row_t x;
    x          = '0;
    x.alu.op   = o;
    x.alu.a    = a;
    x.alu.b    = b;
    x.alu.c    = rand_word();
    x.lsu_rdy  = 1'b1;
    x.wb_rdy   = 1'b1;
    x.rf_alu   = rf_wr_t'(rand_word());
    x.rf_lsu   = rf_wr_t'(rand_word());
    x.mult.a   = rand_word();
    x.mult.b   = rand_word();
    return x;
  endfunction

  // Expected values from the stage rules, then append
  task automatic push_row(string name, row_t x);
    logic [DATA_W:0]     alu_v;
    logic [2*DATA_W-1:0] prod;
    exp_t                e;
    alu_v   = alu_model(x.alu.op, x.alu.a, x.alu.b);
    prod    = {{DATA_W{1'b0}}, x.mult.a} * {{DATA_W{1'b0}}, x.mult.b};
    e.cmp   = alu_v[DATA_W];
    // Priority multiply, then CSR, then ALU
    if (x.mult.en)
      e.wdata = (x.mult.op == MUL_HU) ? prod[2*DATA_W-1:DATA_W] : prod[DATA_W-1:0];
    else if (x.csr_acc)
      e.wdata = x.csr_data;
    else
      e.wdata = alu_v[DATA_W-1:0];
    e.valid = x.lsu_rdy & x.wb_rdy;
    e.ready = e.valid | x.branch;
    rows.push_back(x);
    exps.push_back(e);
    names.push_back(name);
  endtask

  task automatic mult_row(string name, mult_op_e mop, logic [DATA_W-1:0] a,
                          logic [DATA_W-1:0] b);
    row_t x;
    x           = base_row(ADD, rand_word(), rand_word());
    x.mult.en   = 1'b1;
    x.mult.op   = mop;
    x.mult.a    = a;
    x.mult.b    = b;
    push_row(name, x);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    for (int k = 0; k < 16; k++)
    begin
      op = alu_op_e'(k);
      push_row($sformatf("%s fixed", op.name()), base_row(op, 32'hFFFF_FFF9, 32'h0000_0003));
      push_row($sformatf("%s random", op.name()), base_row(op, rand_word(), rand_word()));
    end
    // Sign boundary and equal operands
    push_row("LT edge", base_row(LT, 32'h8000_0000, 32'h7FFF_FFFF));
    push_row("LTU edge", base_row(LTU, 32'h8000_0000, 32'h7FFF_FFFF));
    push_row("EQ equal", base_row(EQ, 32'h1234_5678, 32'h1234_5678));
    // CSR overrides ALU, multiply overrides both
    r          = base_row(ADD, rand_word(), rand_word());
    r.csr_acc  = 1'b1;
    r.csr_data = rand_word();
    push_row("csr override", r);
    r           = base_row(SUB, rand_word(), rand_word());
    r.csr_acc   = 1'b1;
    r.csr_data  = rand_word();
    r.mult.en   = 1'b1;
    r.mult.op   = MUL_LO;
    push_row("mult over csr", r);
    mult_row("mul lo ones", MUL_LO, '1, '1);
    mult_row("mul hu ones", MUL_HU, '1, '1);
    mult_row("mul hu zero", MUL_HU, '0, rand_word());
    mult_row("mul lo one", MUL_LO, 32'd1, rand_word());
    for (int k = 0; k < 4; k++)
      mult_row($sformatf("mul random %0d", k), mult_op_e'(k[0]), rand_word(), rand_word());
    // EX/WB register load, hold, flush and address keep
    r        = base_row(OR, rand_word(), rand_word());
    r.rf_lsu = '{we: 1'b1, waddr: 5'd17};
    push_row("wb load", r);
    r        = base_row(AND, rand_word(), rand_word());
    r.wb_rdy = 1'b0;
    r.rf_lsu = '{we: 1'b1, waddr: 5'd3};
    push_row("wb stall hold", r);
    r         = base_row(XOR, rand_word(), rand_word());
    r.lsu_rdy = 1'b0;
    push_row("lsu stall flush", r);
    r        = base_row(ADD, rand_word(), rand_word());
    r.rf_lsu = '{we: 1'b0, waddr: 5'd9};
    push_row("wb no write", r);
    // Branch resolves even under back-pressure
    r        = base_row(EQ, 32'd42, 32'd42);
    r.branch = 1'b1;
    r.wb_rdy = 1'b0;
    push_row("branch stalled", r);
    r        = base_row(NE, rand_word(), rand_word());
    r.branch = 1'b1;
    push_row("branch ready", r);
  endtask

  ////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs(row_t x);
    alu_req_i      = x.alu;
    mult_req_i     = x.mult;
    csr_access_i   = x.csr_acc;
    csr_rdata_i    = x.csr_data;
    branch_in_ex_i = x.branch;
    rf_alu_i       = x.rf_alu;
    rf_lsu_i       = x.rf_lsu;
    lsu_ready_ex_i = x.lsu_rdy;
    wb_ready_i     = x.wb_rdy;
  endtask

  task automatic check(string name, string what, logic [63:0] exp_v, logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("ERR %s %s: expected %0h, actual %0h", name, what, exp_v, act_v);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // EX/WB register model, one call per rising edge
  task automatic wb_step(logic valid, logic wb_rdy, rf_wr_t lsu);
    if (valid)
    begin
      wb_m.we = lsu.we;
      if (lsu.we)
        wb_m.waddr = lsu.waddr;
    end
    else if (wb_rdy)
      wb_m.we = 1'b0;
  endtask

  task automatic check_wb(string name);
    check(name, "rf_wb_o", 64'(wb_m), 64'(rf_wb_o));
  endtask

  initial
  begin
    seed  = 89972;
    rst_n = 1'b0;
    wb_m  = '0;
    drive_inputs('0);
    build_table();
    limit_cyc = rows.size() * (DATA_W + 8) + 100;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check("reset", "rf_wb_o.we", 64'd0, 64'(rf_wb_o.we));
    check("reset", "mult_multicycle_o", 64'd0, 64'(mult_multicycle_o));

    for (int i = 0; i < rows.size(); i++)
    begin
      @(negedge clk);
      drive_inputs(rows[i]);
      #1;
      n = 0;
      check_wb(names[i]);
      // Decode holds a multiply until EX is ready
      while (rows[i].mult.en && !ex_ready_o && n <= DATA_W + 2)
      begin
        check(names[i], "ex_valid_o busy", 64'd0, 64'(ex_valid_o));
        if (n > 0)
          check(names[i], "mult_multicycle_o busy", 64'd1, 64'(mult_multicycle_o));
        wb_step(1'b0, rows[i].wb_rdy, rows[i].rf_lsu);
        @(negedge clk);
        #1;
        n++;
        check_wb(names[i]);
      end
      if (rows[i].mult.en)
        check(names[i], "cycles to valid", 64'(DATA_W + 1), 64'(n));
      check(names[i], "fw_o.wdata", 64'(exps[i].wdata), 64'(fw_o.wdata));
      check(names[i], "fw_o.rf", 64'(rows[i].rf_alu), 64'(fw_o.rf));
      check(names[i], "branch_decision_o", 64'(exps[i].cmp), 64'(branch_decision_o));
      check(names[i], "jump_target_o", 64'(rows[i].alu.c), 64'(jump_target_o));
      check(names[i], "ex_valid_o", 64'(exps[i].valid), 64'(ex_valid_o));
      check(names[i], "ex_ready_o", 64'(exps[i].ready), 64'(ex_ready_o));
      check(names[i], "mult_multicycle_o", 64'd0, 64'(mult_multicycle_o));
      wb_step(exps[i].valid, rows[i].wb_rdy, rows[i].rf_lsu);
    end

    // Last register update
    @(negedge clk);
    #1;
    check_wb("final");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage.sv
/*
  Execute stage top level with ALU, iterative multiplier,
  stall control and EX/WB register
*/

`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
#(
  parameter int unsigned DATA_W = ex_pkg::DATA_W
)
(
  input  logic              clk,
  input  logic              rst_n,

  // Operations from decode
  input  alu_req_t          alu_req_i,
  input  mult_req_t         mult_req_i,
  input  logic              csr_access_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic              branch_in_ex_i,
  input  rf_wr_t            rf_alu_i,
  // Passed on to WB untouched
  input  rf_wr_t            rf_lsu_i,

  // Stall inputs
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,

  // Forwarding and WB write port
  output fw_t               fw_o,
  output rf_wr_t            rf_wb_o,

  // Towards fetch
  output logic [DATA_W-1:0] jump_target_o,
  output logic              branch_decision_o,

  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;

  // Branch handling
  assign jump_target_o     = alu_req_i.c;
  assign branch_decision_o = alu_cmp;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  ex_alu #(
    .DATA_W   (DATA_W)
  ) u_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  ex_mult #(
    .DATA_W       (DATA_W)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////
  // Control and EX/WB register
  ////////////////////////////////////////////////////////////

  ex_ctrl #(
    .DATA_W         (DATA_W)
  ) u_ctrl (
    .mult_en_i      (mult_req_i.en),
    .mult_ready_i   (mult_ready),
    .csr_access_i   (csr_access_i),
    .csr_rdata_i    (csr_rdata_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .rf_alu_i       (rf_alu_i),
    .branch_in_ex_i (branch_in_ex_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fw_o           (fw_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ex_wb_reg #(
    .REG_ADDR_W (REG_ADDR_W)
  ) u_wb_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid_i (ex_valid_o),
    .wb_ready_i (wb_ready_i),
    .rf_i       (rf_lsu_i),
    .rf_o       (rf_wb_o)
  );

endmodule

`default_nettype wire

//--- ex_wb_reg.sv
/*
  EX/WB pipeline register for the load/store write port
*/

`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg
  import ex_pkg::*;
#(
  parameter int unsigned REG_ADDR_W = ex_pkg::REG_ADDR_W
)
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ex_valid_i,
  input  logic   wb_ready_i,
  input  rf_wr_t rf_i,
  output rf_wr_t rf_o
);

  ////////////////////////////////////////////////////////////
  // Register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rf_o.we    <= 1'b0;
      rf_o.waddr <= {REG_ADDR_W{1'b0}};
    end
    else
    begin
      if (ex_valid_i)
      begin
        // Valid implies WB is ready
        rf_o.we <= rf_i.we;
        // Address only moves with a real write
        if (rf_i.we)
          rf_o.waddr <= rf_i.waddr;
      end
      else if (wb_ready_i)
      begin
        // Empty slot towards WB, flush the write
        rf_o.we <= 1'b0;
      end
      // Otherwise stalled, hold contents
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Write enable must stay known once out of reset
  we_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(rf_o.we))
    else $error("ex_wb_reg: unknown write enable");

endmodule

`default_nettype wire

//--- ex_ctrl.sv
/*
  Stall equations and result priority of the execute stage
*/

`timescale 1ns/1ps
`default_nettype none

module ex_ctrl
  import ex_pkg::*;
#(
  parameter int unsigned DATA_W = ex_pkg::DATA_W
)
(
  input  logic              mult_en_i,
  input  logic              mult_ready_i,
  input  logic              csr_access_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic [DATA_W-1:0] alu_result_i,
  input  logic [DATA_W-1:0] mult_result_i,
  input  rf_wr_t            rf_alu_i,
  input  logic              branch_in_ex_i,
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,
  output fw_t               fw_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic [DATA_W-1:0] alu_csr_result;

  ////////////////////////////////////////////////////////////
  // Result priority
  ////////////////////////////////////////////////////////////

  // CSR read value replaces ALU result
  assign alu_csr_result = csr_access_i ? csr_rdata_i : alu_result_i;

  always_comb
  begin
    fw_o.rf    = rf_alu_i;
    // Multiplier wins over both
    fw_o.wdata = mult_en_i ? mult_result_i : alu_csr_result;
  end

  ////////////////////////////////////////////////////////////
  // Stall equations
  ////////////////////////////////////////////////////////////

  // ALU is always ready, so only multiplier, LSU and WB matter
  assign ex_valid_o = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX without going to WB,
  // hence ready can be high with valid low
  assign ex_ready_o = ex_valid_o | branch_in_ex_i;

endmodule

`default_nettype wire

//--- ex_mult.sv
/*
  Iterative shift-add multiplier, one multiplier bit per cycle,
  returning the low or high word of the unsigned product
*/

`timescale 1ns/1ps
`default_nettype none

module ex_mult
  import ex_pkg::*;
#(
  parameter int unsigned DATA_W = ex_pkg::DATA_W
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  mult_req_t         req_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  localparam int unsigned CNT_W = $clog2(DATA_W + 1);

  mult_state_e           state_q;
  mult_state_e           state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic [2*DATA_W-1:0]   prod_q;
  logic [2*DATA_W-1:0]   mcand_q;
  logic [DATA_W-1:0]     mplier_q;
  logic                  start;
  logic                  last;

  assign start = (state_q == IDLE) && req_i.en;
  // Final multiplier bit being processed
  assign last  = (cnt_q == CNT_W'(DATA_W - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (req_i.en) state_d = BUSY;
      BUSY:    if (last) state_d = DONE;
      // Hold the product until EX hands over
      DONE:    if (ex_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (start)
        cnt_q <= '0;
      else if (state_q == BUSY)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      prod_q   <= '0;
      mcand_q  <= {{DATA_W{1'b0}}, req_i.a};
      mplier_q <= req_i.b;
    end
    else if (state_q == BUSY)
    begin
      // Accumulate on a set multiplier bit
      if (mplier_q[0])
        prod_q <= prod_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Word select
  assign result_o     = (req_i.op == MUL_HU) ? prod_q[2*DATA_W-1:DATA_W] : prod_q[DATA_W-1:0];
  // Not ready from the first enable cycle until DONE
  assign ready_o      = (state_q == DONE) || ((state_q == IDLE) && !req_i.en);
  assign multicycle_o = (state_q == BUSY);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == BUSY) |-> (cnt_q < CNT_W'(DATA_W)))
    else $error("ex_mult: bit counter out of range");

  // DATA_W busy cycles, then DONE
  busy_length: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> (state_q == BUSY) [*DATA_W] ##1 (state_q == DONE))
    else $error("ex_mult: wrong busy length");

endmodule

`default_nettype wire

//--- ex_alu.sv
/*
  Single-cycle ALU with add/sub, logic, barrel shifts and compares
  sharing one adder-subtractor, plus the branch compare output
*/

`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
#(
  parameter int unsigned DATA_W = ex_pkg::DATA_W
)
(
  input  alu_req_t          req_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_o
);

  localparam int unsigned SHAMT_W = $clog2(DATA_W);

  logic [DATA_W-1:0]  op_a;
  logic [DATA_W-1:0]  op_b;
  logic               is_add;
  logic [DATA_W-1:0]  b_mux;
  logic [DATA_W:0]    adder;
  logic [SHAMT_W-1:0] shamt;
  logic               eq;
  logic               lts;
  logic               ltu;

  assign op_a  = req_i.a;
  assign op_b  = req_i.b;
  // Shift amount from low bits of b
  assign shamt = op_b[SHAMT_W-1:0];

  ////////////////////////////////////////////////////////////
  // Shared adder-subtractor
  ////////////////////////////////////////////////////////////

  // Everything except ADD subtracts
  assign is_add = (req_i.op == ADD);
  assign b_mux  = is_add ? op_b : ~op_b;
  // Extra top bit holds the carry out
  assign adder  = {1'b0, op_a} + {1'b0, b_mux} + {{DATA_W{1'b0}}, ~is_add};

  // Compares derived from the difference
  assign eq  = (adder[DATA_W-1:0] == '0);
  // No carry out of a + ~b + 1 means a borrow
  assign ltu = ~adder[DATA_W];
  // Sign bits differ -> a negative means less than
  assign lts = (op_a[DATA_W-1] ^ op_b[DATA_W-1]) ? op_a[DATA_W-1] : adder[DATA_W-1];

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o = '0;
    unique case (req_i.op)
      ADD, SUB: result_o = adder[DATA_W-1:0];
      AND:      result_o = op_a & op_b;
      OR:       result_o = op_a | op_b;
      XOR:      result_o = op_a ^ op_b;
      SLL:      result_o = op_a << shamt;
      SRL:      result_o = op_a >> shamt;
      SRA:      result_o = $signed(op_a) >>> shamt;
      SLT:      result_o = {{(DATA_W-1){1'b0}}, lts};
      SLTU:     result_o = {{(DATA_W-1){1'b0}}, ltu};
      // Branch compares leave the word at zero
      default:  result_o = '0;
    endcase
  end

  // Compare output, also set for SLT and SLTU
  always_comb
  begin
    cmp_o = 1'b0;
    unique case (req_i.op)
      EQ:        cmp_o = eq;
      NE:        cmp_o = ~eq;
      LT, SLT:   cmp_o = lts;
      GE:        cmp_o = ~lts;
      LTU, SLTU: cmp_o = ltu;
      GEU:       cmp_o = ~ltu;
      default:   cmp_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Every 4-bit code is defined, so a known op is a legal op
  always_comb
  begin
    op_legal: assert final (!$isunknown(req_i.op))
      else $error("ex_alu: illegal operation code");
  end

endmodule

`default_nettype wire

//--- ex_pkg.sv
/*
  Shared widths, operation and state enums, and the request and
  result structs of the execute stage
*/

`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Default operand width for the whole stage
  parameter int unsigned DATA_W     = 32;
  // Register file address width
  parameter int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // Operation and state encodings
  ////////////////////////////////////////////////////////////

  // ALU operations, all 16 codes in use
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    // Branch compares, result word is zero
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // Low or high word of the unsigned product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mult_op_e;

  // Iterative multiplier states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } mult_state_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // ALU request from decode; c carries the jump target
  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] c;
  } alu_req_t;

  // Multiplier request from decode
  typedef struct packed {
    logic              en;
    mult_op_e          op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } mult_req_t;

  // Register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
  } rf_wr_t;

  // Forwarding port towards decode and register file
  typedef struct packed {
    rf_wr_t            rf;
    logic [DATA_W-1:0] wdata;
  } fw_t;

endpackage

`default_nettype wire
